// ==== hw/i2c_pkg.sv ====
package i2c_pkg;

    // bit engine commands issued by the sequencer
    typedef enum logic [1:0]
    {
        CMD_START = 2'd0,
        CMD_STOP  = 2'd1,
        CMD_WRITE = 2'd2, // 8 bits out, ack sampled
        CMD_READ  = 2'd3  // 8 bits in, nack sent
    } i2c_cmd_t;

    // bit engine phases
    typedef enum logic [2:0]
    {
        PH_IDLE   = 3'd0,
        PH_START  = 3'd1,
        PH_BIT    = 3'd2, // one of the eight data bits
        PH_ACKBIT = 3'd3, // ninth bit
        PH_STOP   = 3'd4
    } i2c_phase_t;

endpackage

// ==== hw/eeprom_pkg.sv ====
package eeprom_pkg;

    // 2 kB array, word address width
    localparam int ADDR_W = 11;

    // upper nibble of the control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // request sequencer states
    typedef enum logic [3:0]
    {
        S_IDLE    = 4'd0,
        S_START   = 4'd1,
        S_CTRL_W  = 4'd2,
        S_ADDR    = 4'd3,
        S_DATA_W  = 4'd4,
        S_RESTART = 4'd5, // repeated start, reads only
        S_CTRL_R  = 4'd6,
        S_DATA_R  = 4'd7,
        S_STOP    = 4'd8,
        S_DONE    = 4'd9  // one cycle, ack to host
    } seq_state_t;

endpackage

// ==== hw/i2c_bit_engine.sv ====
`timescale 1ns/100ps

module i2c_bit_engine
    import i2c_pkg::*;
#(
    parameter int CLK_DIV = 4
)
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       cmd_valid,
    input  i2c_cmd_t   cmd,
    input  logic [7:0] tx_byte,
    input  logic       sda_in,
    output logic       cmd_ready,
    output logic       cmd_done,
    output logic [7:0] rx_byte,
    output logic       rx_nack,
    output logic       scl,
    output logic       sda_oe
);

    localparam int DIV_W = $clog2(CLK_DIV);

    i2c_phase_t       phase;
    i2c_phase_t       phase_nxt;
    i2c_cmd_t         op;
    i2c_cmd_t         op_nxt;
    logic [1:0]       quarter;
    logic [1:0]       quarter_nxt;
    logic [DIV_W-1:0] div_cnt;
    logic [DIV_W-1:0] div_nxt;
    logic [2:0]       bit_cnt;
    logic [2:0]       bit_nxt;
    logic [7:0]       shreg;
    logic [7:0]       shreg_nxt;
    logic             nack_nxt;
    logic             last_tick;
    logic             scl_nxt;
    logic             oe_nxt;

    assign cmd_ready = (phase == PH_IDLE);
    assign cmd_done  = last_tick;
    assign rx_byte   = shreg; // valid with cmd_done of a read

    // quarter and bit sequencing
    always_comb
    begin
        phase_nxt   = phase;
        op_nxt      = op;
        quarter_nxt = quarter;
        div_nxt     = div_cnt;
        bit_nxt     = bit_cnt;
        shreg_nxt   = shreg;
        nack_nxt    = rx_nack;
        last_tick   = 1'b0;
        if (phase == PH_IDLE)
        begin
            if (cmd_valid)
            begin
                op_nxt      = cmd;
                shreg_nxt   = tx_byte;
                quarter_nxt = 2'd0;
                div_nxt     = '0;
                bit_nxt     = 3'd0;
                case (cmd)
                    CMD_START: phase_nxt = PH_START;
                    CMD_STOP:  phase_nxt = PH_STOP;
                    default:   phase_nxt = PH_BIT;
                endcase
            end
        end
        else if (div_cnt == DIV_W'(CLK_DIV - 1))
        begin
            div_nxt     = '0;
            quarter_nxt = quarter + 2'd1; // wraps 3 -> 0
            if (quarter == 2'd1) // middle of scl high
            begin
                if (phase == PH_BIT && op == CMD_READ)
                    shreg_nxt = {shreg[6:0], sda_in};
                if (phase == PH_ACKBIT && op == CMD_WRITE)
                    nack_nxt = sda_in;
            end
            if (quarter == 2'd3)
            begin
                if (phase == PH_BIT)
                begin
                    if (op == CMD_WRITE)
                        shreg_nxt = {shreg[6:0], 1'b0};
                    if (bit_cnt == 3'd7)
                        phase_nxt = PH_ACKBIT;
                    else
                        bit_nxt = bit_cnt + 3'd1;
                end
                else
                begin
                    phase_nxt = PH_IDLE;
                    last_tick = 1'b1;
                end
            end
        end
        else
        begin
            div_nxt = div_cnt + DIV_W'(1);
        end
    end

    // bus levels for the quarter being entered
    always_comb
    begin
        scl_nxt = scl;
        oe_nxt  = sda_oe;
        case (phase_nxt)
            PH_START:
            begin
                case (quarter_nxt)
                    2'd0: oe_nxt = 1'b0; // scl stays where it was
                    2'd1: {scl_nxt, oe_nxt} = 2'b10;
                    2'd2: {scl_nxt, oe_nxt} = 2'b11; // sda falls, scl high
                    default: {scl_nxt, oe_nxt} = 2'b01;
                endcase
            end
            PH_STOP:
            begin
                case (quarter_nxt)
                    2'd0: {scl_nxt, oe_nxt} = 2'b01;
                    2'd1: {scl_nxt, oe_nxt} = 2'b11;
                    default: {scl_nxt, oe_nxt} = 2'b10; // sda rises, scl high
                endcase
            end
            PH_BIT, PH_ACKBIT:
            begin
                scl_nxt = (quarter_nxt == 2'd1) || (quarter_nxt == 2'd2);
                if (quarter_nxt == 2'd0)
                begin
                    // data only changes in quarter 0; ack bit is always released
                    if (phase_nxt == PH_BIT && op_nxt == CMD_WRITE)
                        oe_nxt = ~shreg_nxt[7];
                    else
                        oe_nxt = 1'b0;
                end
            end
            default: ; // idle holds the bus
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase   <= PH_IDLE;
            quarter <= 2'd0;
            div_cnt <= '0;
            bit_cnt <= 3'd0;
            rx_nack <= 1'b0;
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
        end
        else
        begin
            phase   <= phase_nxt;
            quarter <= quarter_nxt;
            div_cnt <= div_nxt;
            bit_cnt <= bit_nxt;
            rx_nack <= nack_nxt;
            scl     <= scl_nxt;
            sda_oe  <= oe_nxt;
        end
        shreg <= shreg_nxt;
        op    <= op_nxt;
    end

    a_cmd_when_ready: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> cmd_ready);

    // only start and stop may move sda under a high clock
    a_sda_stable_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && !$stable(sda_oe)) |-> (phase inside {PH_START, PH_STOP}));

endmodule

// ==== hw/eeprom_seq.sv ====
`timescale 1ns/100ps

module eeprom_seq
    import eeprom_pkg::*, i2c_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  logic [ADDR_W-1:0] addr,
    input  logic [7:0]        wdata,
    input  logic              cmd_ready,
    input  logic              cmd_done,
    input  logic [7:0]        rx_byte,
    input  logic              rx_nack,
    output logic              cmd_valid,
    output i2c_cmd_t          cmd,
    output logic [7:0]        tx_byte,
    output logic [7:0]        rdata,
    output logic              ack,
    output logic              busy,
    output logic              nack_err
);

    seq_state_t        state;
    seq_state_t        state_nxt;
    logic              is_read;
    logic [ADDR_W-1:0] addr_r;
    logic [7:0]        wdata_r;
    logic              req;
    logic              issue;
    i2c_cmd_t          issue_cmd;
    logic [7:0]        issue_byte;
    logic [2:0]        addr_hi;

    assign req     = (state == S_IDLE || state == S_DONE) && (wr || rd);
    assign addr_hi = addr_r[ADDR_W-1:8]; // block select bits of the control byte
    assign ack     = (state == S_DONE);
    assign busy    = (state != S_IDLE) && (state != S_DONE);

    always_comb
    begin
        state_nxt = state;
        case (state)
            S_IDLE, S_DONE:
                state_nxt = req ? S_START : S_IDLE;
            S_START:
                if (cmd_done)
                    state_nxt = S_CTRL_W;
            S_CTRL_W:
                if (cmd_done)
                    state_nxt = rx_nack ? S_STOP : S_ADDR;
            S_ADDR:
                if (cmd_done)
                    state_nxt = rx_nack ? S_STOP : (is_read ? S_RESTART : S_DATA_W);
            S_DATA_W:
                if (cmd_done)
                    state_nxt = S_STOP;
            S_RESTART:
                if (cmd_done)
                    state_nxt = S_CTRL_R;
            S_CTRL_R:
                if (cmd_done)
                    state_nxt = rx_nack ? S_STOP : S_DATA_R;
            S_DATA_R:
                if (cmd_done)
                    state_nxt = S_STOP;
            S_STOP:
                if (cmd_done)
                    state_nxt = S_DONE;
            default:
                state_nxt = S_IDLE;
        endcase
    end

    // command for the state being entered
    always_comb
    begin
        issue_cmd  = CMD_WRITE;
        issue_byte = 8'h00;
        case (state_nxt)
            S_START, S_RESTART: issue_cmd = CMD_START;
            S_CTRL_W:           issue_byte = {DEV_CODE, addr_hi, 1'b0};
            S_ADDR:             issue_byte = addr_r[7:0];
            S_DATA_W:           issue_byte = wdata_r;
            S_CTRL_R:           issue_byte = {DEV_CODE, addr_hi, 1'b1};
            S_DATA_R:           issue_cmd = CMD_READ;
            S_STOP:             issue_cmd = CMD_STOP;
            default: ;
        endcase
    end

    assign issue = (state_nxt != state) && (state_nxt != S_IDLE) && (state_nxt != S_DONE);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            cmd_valid <= 1'b0;
            nack_err  <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if (cmd_valid && cmd_ready)
                cmd_valid <= 1'b0;
            if (issue)
                cmd_valid <= 1'b1;
            if (req)
                nack_err <= 1'b0;
            else if (cmd_done && rx_nack &&
                     (state inside {S_CTRL_W, S_ADDR, S_DATA_W, S_CTRL_R}))
                nack_err <= 1'b1;
        end
        if (req)
        begin
            is_read <= !wr; // write wins if both
            addr_r  <= addr;
            wdata_r <= wdata;
        end
        if (issue)
        begin
            cmd     <= issue_cmd;
            tx_byte <= issue_byte;
        end
        if (state == S_DATA_R && cmd_done)
            rdata <= rx_byte;
    end

    a_no_wr_rd: assert property (@(posedge CLK) disable iff (RESET)
        !(wr && rd));

    // engine takes each command in the cycle it is offered
    a_valid_single: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |=> !cmd_valid);

endmodule

// ==== hw/eeprom_top.sv ====
`timescale 1ns/100ps

module eeprom_top
    import eeprom_pkg::*, i2c_pkg::*;
#(
    parameter int CLK_DIV = 4 // clk cycles per quarter scl period
)
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  logic [ADDR_W-1:0] addr,
    input  logic [7:0]        wdata,
    input  logic              sda_in,
    output logic [7:0]        rdata,
    output logic              ack,
    output logic              busy,
    output logic              nack_err,
    output logic              scl,
    output logic              sda_oe
);

    logic       cmd_valid;
    logic       cmd_ready;
    logic       cmd_done;
    i2c_cmd_t   cmd;
    logic [7:0] tx_byte;
    logic [7:0] rx_byte;
    logic       rx_nack;

    eeprom_seq u_seq
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .cmd_ready (cmd_ready),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .rx_nack   (rx_nack),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .rdata     (rdata),
        .ack       (ack),
        .busy      (busy),
        .nack_err  (nack_err)
    );

    i2c_bit_engine #(.CLK_DIV(CLK_DIV)) u_bit
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .sda_in    (sda_in),
        .cmd_ready (cmd_ready),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .rx_nack   (rx_nack),
        .scl       (scl),
        .sda_oe    (sda_oe)
    );

endmodule

// ==== dv/eeprom_slave_model.sv ====
`timescale 1ns/100ps

module eeprom_slave_model
    import eeprom_pkg::*;
(
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic ack_en,  // low withholds every acknowledge
    output logic sda_oe,
    output int   violations
);

    typedef enum logic [1:0] {M_IDLE, M_RX, M_TX, M_WAIT} mode_t;

    logic [7:0]        mem [0:(1<<ADDR_W)-1];
    mode_t             mode;
    logic              scl_q;
    logic              sda_q;
    logic [3:0]        bit_cnt; // rising edges seen in this byte, 9 = ack slot
    logic [7:0]        shift;
    logic [1:0]        byte_idx;
    logic [2:0]        block;
    logic [ADDR_W-1:0] ptr;
    logic              go_tx;
    logic [7:0]        tx_data;

    // erased fill, differs per address
    initial
    begin
        for (int i = 0; i < (1 << ADDR_W); i++)
            mem[i] = 8'(i) ^ {3'(i >> 8), 5'b10110};
    end

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            mode       <= M_IDLE;
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            sda_oe     <= 1'b0;
            bit_cnt    <= 4'd0;
            byte_idx   <= 2'd0;
            go_tx      <= 1'b0;
            violations <= 0;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && (sda != sda_q)) // start or stop
            begin
                // the clock high that carries a start or stop counts as the first edge
                if ((mode == M_RX || mode == M_TX) && bit_cnt > 4'd1)
                begin
                    $display("slave model: start or stop inside a byte at %0t", $time);
                    violations <= violations + 1;
                end
                mode     <= sda ? M_IDLE : M_RX;
                byte_idx <= 2'd0;
                bit_cnt  <= 4'd0;
                sda_oe   <= 1'b0;
                go_tx    <= 1'b0;
            end
            else if (scl && !scl_q && (mode == M_RX || mode == M_TX))
            begin
                shift   <= {shift[6:0], sda};
                bit_cnt <= bit_cnt + 4'd1;
            end
            else if (!scl && scl_q)
            begin
                if (mode == M_RX && bit_cnt == 4'd8)
                begin
                    sda_oe <= ack_en;
                    if (!ack_en)
                        mode <= M_WAIT;
                    if (byte_idx == 2'd0)
                    begin
                        if (shift[7:4] != DEV_CODE)
                        begin
                            $display("slave model: wrong device code %b", shift[7:4]);
                            violations <= violations + 1;
                            sda_oe <= 1'b0;
                            mode   <= M_WAIT;
                        end
                        block   <= shift[3:1];
                        go_tx   <= shift[0] && ack_en;
                        tx_data <= mem[{shift[3:1], ptr[7:0]}];
                    end
                    else if (byte_idx == 2'd1)
                        ptr <= {block, shift};
                    else if (ack_en)
                        mem[ptr] <= shift;
                    if (byte_idx != 2'd3)
                        byte_idx <= byte_idx + 2'd1;
                end
                else if (bit_cnt == 4'd9)
                begin
                    sda_oe  <= 1'b0;
                    bit_cnt <= 4'd0;
                    if (mode == M_TX)
                        mode <= M_WAIT; // master answered, wait for stop
                    else if (go_tx)
                    begin
                        mode   <= M_TX;
                        go_tx  <= 1'b0;
                        sda_oe <= ~tx_data[7];
                    end
                end
                else if (mode == M_TX && bit_cnt == 4'd8)
                    sda_oe <= 1'b0; // master ack slot
                else if (mode == M_TX && bit_cnt != 4'd0)
                    sda_oe <= ~tx_data[3'd7 - bit_cnt[2:0]];
            end
        end
    end

endmodule

// ==== dv/tb_eeprom.sv ====
`timescale 1ns/100ps

module tb_eeprom
    import eeprom_pkg::*;
;

    localparam int CLK_DIV = 4;
    // ~45 requests, a read is about 160 quarter periods
    localparam int MAX_CYCLES = 50 * 200 * CLK_DIV;

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
    logic              sda;
    logic [7:0]        rdata;
    logic              ack;
    logic              busy;
    logic              nack_err;
    logic              scl;
    logic              sda_oe;
    logic              slave_oe;
    logic              ack_en;
    int                violations;

    logic [7:0]        shadow [0:(1<<ADDR_W)-1];
    logic              written [0:(1<<ADDR_W)-1];
    logic [15:0]       lfsr;
    string             test_name;
    logic              exp_nack;
    logic              check_rdata;
    logic [7:0]        exp_rdata;
    int                errors;
    int                errors_at_start;
    int                checks;
    int                cycles;

    assign sda = !sda_oe && !slave_oe; // wired-AND of both pull-downs

    eeprom_top #(.CLK_DIV(CLK_DIV)) dut
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .sda_in   (sda),
        .rdata    (rdata),
        .ack      (ack),
        .busy     (busy),
        .nack_err (nack_err),
        .scl      (scl),
        .sda_oe   (sda_oe)
    );

    eeprom_slave_model slave
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .scl        (scl),
        .sda        (sda),
        .ack_en     (ack_en),
        .sda_oe     (slave_oe),
        .violations (violations)
    );

    always #4 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("run stopped after %0d cycles waiting for the controller", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // unwritten locations read back the erased fill
    function automatic logic [7:0] expected_read(input logic [ADDR_W-1:0] a);
        if (written[a])
            return shadow[a];
        return a[7:0] ^ {a[10:8], 5'b10110};
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    // compare at every ack
    always @(posedge CLK)
    begin
        if (!RESET && ack)
        begin
            checks++;
            if (nack_err !== exp_nack)
            begin
                $display("Error: %s nack_err expected %b actual %b", test_name, exp_nack,
                         nack_err);
                errors++;
            end
            if (check_rdata && rdata !== exp_rdata)
            begin
                $display("Error: %s rdata expected %h actual %h", test_name, exp_rdata, rdata);
                errors++;
            end
        end
    end

    task automatic start_request(input logic is_wr, input logic [ADDR_W-1:0] a,
                                 input logic [7:0] d);
        @(negedge CLK);
        while (busy)
            @(negedge CLK);
        wr    = is_wr;
        rd    = !is_wr;
        addr  = a;
        wdata = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_ack();
        do
            @(posedge CLK);
        while (!ack);
        @(negedge CLK); // leave the ack edge to the compare process
    endtask

    task automatic request(input logic is_wr, input logic [ADDR_W-1:0] a,
                           input logic [7:0] d, input logic nack);
        exp_nack    = nack;
        check_rdata = !is_wr && !nack;
        exp_rdata   = expected_read(a);
        start_request(is_wr, a, d);
        wait_ack();
        if (is_wr && !nack)
        begin
            shadow[a]  = d;
            written[a] = 1'b1;
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        $display("test %s done, %0d errors", test_name, errors - errors_at_start);
    endtask

    initial
    begin
        logic [15:0]       r;
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] b;
        logic [ADDR_W-1:0] last_wr;
        logic [7:0]        d;

        CLK     = 1'b0;
        RESET   = 1'b1;
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        wdata   = 8'h00;
        ack_en  = 1'b1;
        lfsr    = 16'd76;
        errors  = 0;
        checks  = 0;
        cycles  = 0;
        last_wr = '0;
        exp_nack    = 1'b0;
        check_rdata = 1'b0;
        exp_rdata   = 8'h00;
        for (int i = 0; i < (1 << ADDR_W); i++)
        begin
            shadow[i]  = 8'h00;
            written[i] = 1'b0;
        end

        repeat (8) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;

        begin_test("idle_after_reset");
        repeat (20)
        begin
            @(posedge CLK);
            if (scl !== 1'b1 || sda_oe !== 1'b0 || ack !== 1'b0 || busy !== 1'b0)
            begin
                $display("bus or handshake not idle after reset at %0t", $time);
                errors++;
            end
        end
        end_test();

        begin_test("write_then_read");
        take_bits(11, r);
        a = r[10:0];
        take_bits(8, r);
        request(1'b1, a, r[7:0], 1'b0);
        request(1'b0, a, 8'h00, 1'b0);
        end_test();

        begin_test("random_traffic");
        for (int n = 0; n < 30; n++)
        begin
            take_bits(11, r);
            a = r[10:0];
            take_bits(8, r);
            d = r[7:0];
            take_bits(2, r);
            if (r[0])
            begin
                request(1'b1, a, d, 1'b0);
                last_wr = a;
            end
            else
                request(1'b0, r[1] ? last_wr : a, 8'h00, 1'b0); // often re-read
        end
        end_test();

        begin_test("missing_ack");
        take_bits(11, r);
        a = r[10:0];
        take_bits(8, r);
        request(1'b1, a, r[7:0], 1'b0);
        @(negedge CLK);
        ack_en = 1'b0;
        request(1'b1, a, ~r[7:0], 1'b1);
        request(1'b0, a, 8'h00, 1'b1);
        @(negedge CLK);
        ack_en = 1'b1;
        request(1'b0, a, 8'h00, 1'b0);
        end_test();

        begin_test("request_while_busy");
        take_bits(11, r);
        a = r[10:0];
        b = a ^ 11'h400;
        take_bits(8, r);
        exp_nack    = 1'b0;
        check_rdata = 1'b0;
        start_request(1'b1, a, r[7:0]);
        repeat (20) @(negedge CLK);
        if (!busy)
        begin
            $display("busy was low during a write");
            errors++;
        end
        wr    = 1'b1;
        addr  = b;
        wdata = ~expected_read(b);
        @(negedge CLK);
        wr = 1'b0;
        wait_ack();
        shadow[a]  = r[7:0];
        written[a] = 1'b1;
        request(1'b0, b, 8'h00, 1'b0);
        request(1'b0, a, 8'h00, 1'b0);
        end_test();

        if (violations != 0)
        begin
            $display("slave model saw %0d bus protocol violations", violations);
            errors++;
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== tb.f ====
hw/i2c_pkg.sv
hw/eeprom_pkg.sv
hw/i2c_bit_engine.sv
hw/eeprom_seq.sv
hw/eeprom_top.sv
dv/eeprom_slave_model.sv
dv/tb_eeprom.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the EEPROM controller testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    -f tb.f \
    --top-module tb_eeprom \
    -o sim_tb_eeprom

./obj_dir/sim_tb_eeprom | tee "$LOG"

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0
